// File: flist.f
rtl/or_cfg_pkg.sv
rtl/or_stream_pkg.sv
rtl/register_slice.sv
rtl/or_tree_layer.sv
rtl/or_tree.sv
rtl/lane_mask.sv
rtl/or_reduce_unit.sv
tests/tb_clock_gen.sv
tests/tb_or_reduce_unit.sv

// File: rtl/lane_mask.sv
`timescale 1ns/1ps

module lane_mask #(
  parameter int lane_count = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  or_stream_pkg::mask_write_t mask_wr,
  input  or_stream_pkg::lane_word_t  in_data [lane_count],
  input  logic                      in_valid,
  output logic                      in_ready,
  output or_stream_pkg::lane_word_t  masked_data [lane_count],
  output logic                      masked_valid,
  input  logic                      masked_ready
);

  localparam int w = or_cfg_pkg::lane_width;

  logic [lane_count-1:0]   lane_en;      // enable bits above lane_count are dropped.
  logic [lane_count*w-1:0] cleared_flat;
  logic [lane_count*w-1:0] masked_flat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_en <= '1;  // every lane enabled out of reset.
    end else if (mask_wr.en) begin
      lane_en <= mask_wr.lane_en[lane_count-1:0];
    end
  end

  // Disabled lanes are zeroed so they drop out of the OR.
  for (genvar k = 0; k < lane_count; k++) begin : gen_clear
    assign cleared_flat[k*w +: w] = lane_en[k] ? in_data[k] : '0;
    assign masked_data[k]         = masked_flat[k*w +: w];
  end

  register_slice #(
    .data_width(lane_count * w)
  ) u_slice (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in       (cleared_flat),
    .data_in_valid (in_valid),
    .data_in_ready (in_ready),
    .data_out      (masked_flat),
    .data_out_valid(masked_valid),
    .data_out_ready(masked_ready)
  );

endmodule

// File: rtl/or_cfg_pkg.sv
package or_cfg_pkg;

  // geometry of one lane word and of the lane array.
  parameter int lane_width = 32;  // bits per lane word.

  // upper bound on lanes per beat and the width of the mask field.
  parameter int max_lanes = 8;

  // lane count used by the top level unless overridden.
  parameter int default_lane_count = 4;

endpackage

// File: rtl/or_reduce_unit.sv
`timescale 1ns/1ps

module or_reduce_unit #(
  parameter int lane_count = or_cfg_pkg::default_lane_count
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  or_stream_pkg::mask_write_t mask_wr,
  input  or_stream_pkg::lane_word_t  in_data [lane_count],
  input  logic                      in_valid,
  output logic                      in_ready,
  output or_stream_pkg::lane_word_t  out_data,
  output logic                      out_valid,
  input  logic                      out_ready
);

  or_stream_pkg::lane_word_t masked_data [lane_count];  // lanes after the mask stage.
  logic                      masked_valid;
  logic                      masked_ready;

  lane_mask #(
    .lane_count(lane_count)
  ) u_lane_mask (
    .clk         (clk),
    .rst_n       (rst_n),
    .mask_wr     (mask_wr),
    .in_data     (in_data),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .masked_data (masked_data),
    .masked_valid(masked_valid),
    .masked_ready(masked_ready)
  );

  or_tree #(
    .lane_count(lane_count)
  ) u_or_tree (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in       (masked_data),
    .data_in_valid (masked_valid),
    .data_in_ready (masked_ready),
    .data_out      (out_data),
    .data_out_valid(out_valid),
    .data_out_ready(out_ready)
  );

endmodule

// File: rtl/or_stream_pkg.sv
package or_stream_pkg;

  // one status or event word as it travels through the tree.
  typedef logic [or_cfg_pkg::lane_width-1:0] lane_word_t;

  // a software write to the lane enable register.
  typedef struct packed {
    logic                             en;       // high for one cycle per write.
    logic [or_cfg_pkg::max_lanes-1:0] lane_en;  // one enable bit per lane.
  } mask_write_t;

endpackage

// File: rtl/or_tree.sv
`timescale 1ns/1ps

module or_tree #(
  parameter int lane_count = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  or_stream_pkg::lane_word_t data_in [lane_count],
  input  logic                     data_in_valid,
  output logic                     data_in_ready,
  output or_stream_pkg::lane_word_t data_out,
  output logic                     data_out_valid,
  input  logic                     data_out_ready
);

  localparam int w      = or_cfg_pkg::lane_width;
  localparam int levels = $clog2(lane_count) + 1;  // last level passes one lane through.

  logic [lane_count*w-1:0] data_in_flat;
  logic [levels:0]         valid;  // handshake between neighbouring levels.
  logic [levels:0]         ready;

  for (genvar k = 0; k < lane_count; k++) begin : gen_flatten
    assign data_in_flat[k*w +: w] = data_in[k];
  end

  for (genvar i = 0; i < levels; i++) begin : gen_level
    localparam int level_in_size  = (lane_count + ((1 << i) - 1)) >> i;  // ceil(n / 2^i).
    localparam int level_out_size = (level_in_size + 1) / 2;

    logic [level_in_size*w-1:0]  layer_in;
    logic [level_out_size*w-1:0] layer_out;
    logic [level_out_size*w-1:0] slice_out;

    // level i reads the registered lanes of level i-1.
    if (i == 0) begin : gen_first
      assign layer_in = data_in_flat;
    end else begin : gen_chain
      assign layer_in = gen_level[i-1].slice_out;
    end

    or_tree_layer #(
      .in_size(level_in_size)
    ) u_layer (
      .data_in (layer_in),
      .data_out(layer_out)
    );

    register_slice #(
      .data_width(level_out_size * w)
    ) u_slice (
      .clk           (clk),
      .rst_n         (rst_n),
      .data_in       (layer_out),
      .data_in_valid (valid[i]),
      .data_in_ready (ready[i]),
      .data_out      (slice_out),
      .data_out_valid(valid[i+1]),
      .data_out_ready(ready[i+1])
    );
  end

  assign valid[0]      = data_in_valid;
  assign data_in_ready = ready[0];

  assign data_out       = gen_level[levels-1].slice_out[w-1:0];  // single lane is left.
  assign data_out_valid = valid[levels];
  assign ready[levels]  = data_out_ready;

endmodule

// File: rtl/or_tree_layer.sv
`timescale 1ns/1ps

module or_tree_layer #(
  parameter int in_size = 2
) (
  input  logic [in_size*or_cfg_pkg::lane_width-1:0]         data_in,
  output logic [((in_size+1)/2)*or_cfg_pkg::lane_width-1:0] data_out
);

  localparam int w        = or_cfg_pkg::lane_width;
  localparam int out_size = (in_size + 1) / 2;

  // adjacent pairs collapse into one lane each.
  for (genvar k = 0; k < in_size / 2; k++) begin : gen_pair
    assign data_out[k*w +: w] = data_in[2*k*w +: w] | data_in[(2*k+1)*w +: w];
  end

  // An odd lane has no partner and goes straight through.
  if (in_size % 2 == 1) begin : gen_odd
    assign data_out[(out_size-1)*w +: w] = data_in[(in_size-1)*w +: w];
  end

endmodule

// File: rtl/register_slice.sv
`timescale 1ns/1ps

module register_slice #(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [data_width-1:0] data_in,
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [data_width-1:0] data_out,
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  logic                  main_valid;
  logic [data_width-1:0] main_data;
  logic                  spare_valid;
  logic [data_width-1:0] spare_data;
  logic                  in_fire;
  logic                  main_free;

  assign data_in_ready = ~spare_valid;  // only depends on our own occupancy.
  assign in_fire       = data_in_valid & data_in_ready;
  assign main_free     = ~main_valid | data_out_ready;  // main empties this cycle.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid  <= 1'b0;
      spare_valid <= 1'b0;
    end else if (main_free) begin
      if (spare_valid) begin
        main_valid  <= 1'b1;  // the older beat in the spare moves up first.
        spare_valid <= 1'b0;
      end else begin
        main_valid <= in_fire;
      end
    end else if (in_fire) begin
      spare_valid <= 1'b1;  // output stalled, so park the new beat.
    end
  end

  // payload follows the same decisions as the valid bits above.
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (spare_valid) begin
        main_data <= spare_data;
      end else if (in_fire) begin
        main_data <= data_in;
      end
    end else if (in_fire) begin
      spare_data <= data_in;
    end
  end

  assign data_out       = main_data;
  assign data_out_valid = main_valid;

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset is released on a rising edge so the first beat lines up with the clock.
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: tests/tb_or_reduce_unit.sv
`timescale 1ns/1ps

module tb_or_reduce_unit;

  localparam int          lane_count     = 4;
  localparam int          levels         = $clog2(lane_count) + 1;
  localparam int          latency        = levels + 1;  // mask stage plus one slice per level.
  localparam logic [31:0] seed           = 32'h3467_368f;
  localparam int          stream_beats   = 200;
  localparam int          mask_bursts    = 10;
  localparam int          burst_beats    = 10;
  localparam int          stall_beats    = 300;
  localparam int          total_beats    = 1 + stream_beats + mask_bursts * burst_beats
                                           + stall_beats + burst_beats;
  localparam int          timeout_cycles = total_beats * 4 + 200;

  logic                       clk;
  logic                       rst_n;
  or_stream_pkg::mask_write_t mask_wr;
  or_stream_pkg::lane_word_t  in_data [lane_count];
  logic                       in_valid;
  logic                       in_ready;
  or_stream_pkg::lane_word_t  out_data;
  logic                       out_valid;
  logic                       out_ready;

  logic [31:0]                      lfsr_state;
  logic                             stall_mode;  // randomizes out_ready when set.
  logic [or_cfg_pkg::max_lanes-1:0] model_mask;
  or_stream_pkg::lane_word_t        expected_q [$];
  logic                             held_valid;
  or_stream_pkg::lane_word_t        held_data;
  string                            cur_test;
  int cycle_count = 0;
  int accepted;
  int results;
  int last_in_cycle;
  int last_out_cycle;
  int prev_out_cycle;
  int max_gap;
  int errors;
  int test_errors_start;
  int tests_run;
  int tests_failed;

  tb_clock_gen #(
    .period_ns   (20),
    .reset_cycles(8)
  ) u_clock_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  or_reduce_unit #(
    .lane_count(lane_count)
  ) i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .mask_wr  (mask_wr),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data (out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  // Galois form of x^32 + x^31 + x^29 + x + 1 that shifts right.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'hD000_0001;
    end
    return state >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    int          i;
    value = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit taken.
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // advances one clock and picks the out_ready level for the next cycle.
  task automatic tick;
    if (stall_mode) begin
      out_ready <= (take_bits(2) != 32'd0);
    end else begin
      out_ready <= 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic push_beat;
    int k;
    for (k = 0; k < lane_count; k++) begin
      in_data[k] <= take_bits(32);
    end
    in_valid <= 1'b1;
    tick();
    while (!in_ready) tick();  // in_ready still shows the cycle that just ended.
  endtask

  task automatic write_mask(input logic [or_cfg_pkg::max_lanes-1:0] bits);
    in_valid        <= 1'b0;
    mask_wr.en      <= 1'b1;
    mask_wr.lane_en <= bits;
    tick();
    mask_wr.en <= 1'b0;
  endtask

  // returns on a falling edge once every accepted beat has come out.
  task automatic wait_idle;
    in_valid   <= 1'b0;
    out_ready  <= 1'b1;
    stall_mode = 1'b0;
    @(negedge clk);
    while (results < accepted) @(negedge clk);
  endtask

  task automatic mark_start(input string name);
    @(negedge clk);
    cur_test          = name;
    test_errors_start = errors;
    prev_out_cycle    = -1;
    max_gap           = 0;
    @(posedge clk);
  endtask

  task automatic end_test;
    int n;
    n = errors - test_errors_start;
    tests_run++;
    if (n == 0) begin
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, n);
    end
  endtask

  // samples both handshakes on the same edge that the DUT uses.
  always @(posedge clk) begin : monitor
    or_stream_pkg::lane_word_t expected;
    or_stream_pkg::lane_word_t head;
    int                        k;
    cycle_count = cycle_count + 1;
    if (rst_n) begin
      if (held_valid) begin
        if (!out_valid) begin
          errors++;
          $display("test %s: out_valid dropped while the output was stalled", cur_test);
        end else if (out_data !== held_data) begin
          errors++;
          $display("FAILED %s: expected %h actual %h", cur_test, held_data, out_data);
        end
      end
      held_valid = out_valid & ~out_ready;
      held_data  = out_data;
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          errors++;
          $display("test %s: an output beat arrived with no beat outstanding", cur_test);
        end else begin
          head = expected_q.pop_front();
          if (out_data !== head) begin
            errors++;
            $display("FAILED %s: expected %h actual %h", cur_test, head, out_data);
          end
        end
        results++;
        if (prev_out_cycle >= 0 && cycle_count - prev_out_cycle > max_gap) begin
          max_gap = cycle_count - prev_out_cycle;
        end
        prev_out_cycle = cycle_count;
        last_out_cycle = cycle_count;
      end
      if (in_valid && in_ready) begin
        expected = '0;
        for (k = 0; k < lane_count; k++) begin
          if (model_mask[k]) begin
            expected = expected | in_data[k];
          end
        end
        expected_q.push_back(expected);
        accepted++;
        last_in_cycle = cycle_count;
      end
      if (mask_wr.en) begin
        model_mask = mask_wr.lane_en;  // a write counts from the next accepted beat.
      end
    end
  end

  initial begin : watchdog
    wait (cycle_count >= timeout_cycles);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Errors found");
    $finish;
  end

  initial begin : stimulus
    int k;
    int b;
    int start_count;
    logic [or_cfg_pkg::max_lanes-1:0] bits;
    logic [31:0]                      draw;
    lfsr_state = seed;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    mask_wr    = '0;
    for (k = 0; k < lane_count; k++) begin
      in_data[k] = '0;
    end
    stall_mode   = 1'b0;
    model_mask   = '1;  // matches the DUT reset value.
    held_valid   = 1'b0;
    accepted     = 0;
    results      = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "reset";
    wait (rst_n === 1'b1);
    @(posedge clk);

    mark_start("reset_and_latency");
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      errors++;
      $display("test %s: out_valid is not low after reset", cur_test);
    end
    if (in_ready !== 1'b1) begin
      errors++;
      $display("test %s: in_ready is not high after reset", cur_test);
    end
    @(posedge clk);
    push_beat();
    wait_idle();
    if (last_out_cycle - last_in_cycle != latency) begin
      errors++;
      $display("FAILED %s: expected %0d actual %0d", cur_test, latency,
               last_out_cycle - last_in_cycle);
    end
    end_test();

    mark_start("streaming");
    start_count = results;
    repeat (stream_beats) push_beat();
    wait_idle();
    if (max_gap != 1) begin
      errors++;
      $display("FAILED %s: expected %0d actual %0d", cur_test, 1, max_gap);
    end
    if (results - start_count != stream_beats) begin
      errors++;
      $display("FAILED %s: expected %0d actual %0d", cur_test, stream_beats,
               results - start_count);
    end
    end_test();

    mark_start("mask");
    for (b = 0; b < mask_bursts; b++) begin
      if (b == 0) begin
        bits = '0;  // every lane off, so the results must be zero.
      end else if (b == mask_bursts - 1) begin
        bits = '1;
      end else begin
        draw = take_bits(or_cfg_pkg::max_lanes);
        bits = draw[or_cfg_pkg::max_lanes-1:0];
      end
      write_mask(bits);
      repeat (burst_beats) push_beat();
    end
    wait_idle();
    end_test();

    mark_start("back_pressure");
    start_count = results;
    stall_mode  = 1'b1;
    repeat (stall_beats) begin
      if (take_bits(2) == 32'd0) begin
        in_valid <= 1'b0;
        tick();
      end
      push_beat();
    end
    wait_idle();
    if (results - start_count != stall_beats) begin
      errors++;
      $display("FAILED %s: expected %0d actual %0d", cur_test, stall_beats,
               results - start_count);
    end
    end_test();

    mark_start("drain");
    repeat (burst_beats) push_beat();
    in_valid <= 1'b0;
    @(negedge clk);
    while (!out_valid) @(negedge clk);
    while (out_valid) @(negedge clk);  // the last result has left the tree.
    repeat (latency + 2) begin
      @(negedge clk);
      if (out_valid) begin
        errors++;
        $display("test %s: out_valid rose after every beat had come out", cur_test);
      end
    end
    if (expected_q.size() != 0) begin
      errors++;
      $display("FAILED %s: expected %0d actual %0d", cur_test, 0, expected_q.size());
    end
    if (results != accepted) begin
      errors++;
      $display("FAILED %s: expected %0d actual %0d", cur_test, accepted, results);
    end
    end_test();

    $display("%0d tests run, %0d tests failed, %0d checks failed", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
